// File: verilog/fifo_reader_defines.svh
`ifndef FIFO_READER_DEFINES_SVH
`define FIFO_READER_DEFINES_SVH

// Receive FIFOs sharing the word memory
`define NUM_PORTS	4
`define PORT_BITS	2

// Word index inside one FIFO, and the same with its wrap bit
`define PTR_BITS	8
`define FIFO_PTR_W	9

// Frame fields
`define LEN_W		11
`define WORD_W		64
`define VLAN_W		12
`define MAC_W		48

// Queue depths and the counters that hold 0 to depth
`define TAG_DEPTH	8
`define OUT_DEPTH	8
`define TAG_CNT_W	4
`define OUT_CNT_W	4

// Port index joined to word index
`define MEM_ADDR_W	10

`endif

// File: verilog/fifo_reader_pkg.sv
`include "fifo_reader_defines.svh"

package fifo_reader_pkg;

	// Why a memory read was issued
	typedef enum logic [1:0] {
		MT_HEADER,
		MT_WORD0,
		MT_WORD1,
		MT_BODY
	} mtype_e;

	// Travels with each read until the data comes back
	typedef struct packed {
		mtype_e mtype;
		logic [`PORT_BITS-1:0] port;
	} read_tag_t;

	// Header word layout, written by the receive side
	typedef struct packed {
		logic [`WORD_W-1:28] rsvd_hi;
		logic [`VLAN_W-1:0] vlan;
		logic [15:`LEN_W] rsvd_lo;
		logic [`LEN_W-1:0] len;
	} hdr_fields_t;

	// Header words decode as fields, payload words as bytes
	// Byte 0 sits in the low bits and is first on the wire
	typedef union packed {
		hdr_fields_t hdr;
		logic [`WORD_W/8-1:0][7:0] bytes;
	} mem_word_u;

	typedef struct packed {
		logic [`PORT_BITS-1:0] port;
		logic [`VLAN_W-1:0] vlan;
		logic [`MAC_W-1:0] src_mac;
		logic [`MAC_W-1:0] dst_mac;
	} lookup_req_t;

	// Port field tags the result back to its receive FIFO
	typedef struct packed {
		logic [`PORT_BITS-1:0] port;
		logic [`PORT_BITS-1:0] dst_port;
		logic broadcast;
	} lookup_rsp_t;

	typedef struct packed {
		logic [`WORD_W-1:0] data;
		logic [`WORD_W/8-1:0] strb;
		logic last;
		logic [`PORT_BITS-1:0] dst_port;
		logic broadcast;
		logic [`VLAN_W-1:0] vlan;
	} tx_beat_t;

	typedef enum logic [2:0] {
		PS_IDLE,
		PS_HEADER,
		PS_WORD0,
		PS_WORD1,
		PS_LOOKUP,
		PS_FWD_READY,
		PS_FORWARDING
	} port_state_e;

	typedef enum logic [1:0] {
		FS_IDLE,
		FS_BEAT0,
		FS_BEAT1,
		FS_BODY
	} fwd_step_e;

	typedef logic [`NUM_PORTS-1:0][`FIFO_PTR_W-1:0] ptr_vec_t;

endpackage

// File: verilog/read_tag_fifo.sv
`include "fifo_reader_defines.svh"

module read_tag_fifo (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  fifo_reader_pkg::read_tag_t push_tag,
	input  logic pop,
	output fifo_reader_pkg::read_tag_t head_tag,
	output logic [`TAG_CNT_W-1:0] count
);

	localparam int IDX_W = $clog2(`TAG_DEPTH);

	// One tag per memory read still outstanding
	fifo_reader_pkg::read_tag_t tags [`TAG_DEPTH];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;

	always_ff @(posedge clk) begin
		if (push)
			tags[wr_idx] <= push_tag;
	end

	// Depth is a power of two so indices wrap on their own
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_idx <= wr_idx + 1'b1;
			if (pop)
				rd_idx <= rd_idx + 1'b1;
			count <= count + `TAG_CNT_W'(push) - `TAG_CNT_W'(pop);
		end
	end

	// Head shown without a register, returned data is steered in its own cycle
	assign head_tag = tags[rd_idx];

endmodule

// File: verilog/port_frame_table.sv
`include "fifo_reader_defines.svh"

module port_frame_table (
	input  logic clk,
	input  logic rst_n,
	input  logic rd_valid,
	input  fifo_reader_pkg::mem_word_u rd_data,
	input  fifo_reader_pkg::read_tag_t head_tag,
	input  logic rsp_valid,
	input  fifo_reader_pkg::lookup_rsp_t rsp,
	input  logic [`PORT_BITS-1:0] sel_port,
	output fifo_reader_pkg::lookup_req_t req,
	output logic req_valid,
	input  logic req_ready,
	output logic [`LEN_W-1:0] sel_len,
	output logic [`VLAN_W-1:0] sel_vlan,
	output logic [`WORD_W-1:0] sel_beat0,
	output logic [`WORD_W-1:0] sel_beat1,
	output fifo_reader_pkg::lookup_rsp_t sel_route
);

	////////////////////////////////////////////////////////////
	// Per-port fields of the frame at the head of each FIFO

	logic [`LEN_W-1:0] len_tab [`NUM_PORTS];
	logic [`VLAN_W-1:0] vlan_tab [`NUM_PORTS];
	logic [`MAC_W-1:0] dst_tab [`NUM_PORTS];
	logic [`MAC_W-1:0] src_tab [`NUM_PORTS];
	// Kept in wire byte order, goes straight back into beat1
	logic [3:0][7:0] first4_tab [`NUM_PORTS];
	fifo_reader_pkg::lookup_rsp_t route_tab [`NUM_PORTS];

	// MAC fields arrive first byte first, flip into MSB-first order
	logic [`MAC_W-1:0] w0_dst;
	logic [15:0] w0_src_hi;
	logic [31:0] w1_src_lo;
	logic word1_ret;
	logic [`PORT_BITS-1:0] p;

	always_comb begin
		w0_dst = {<<8{rd_data.bytes[5:0]}};
		w0_src_hi = {<<8{rd_data.bytes[7:6]}};
		w1_src_lo = {<<8{rd_data.bytes[3:0]}};
		p = head_tag.port;
		word1_ret = rd_valid && (head_tag.mtype == fifo_reader_pkg::MT_WORD1);
	end

	always_ff @(posedge clk) begin
		if (rd_valid) begin
			case (head_tag.mtype)
				fifo_reader_pkg::MT_HEADER: begin
					len_tab[p] <= rd_data.hdr.len;
					vlan_tab[p] <= rd_data.hdr.vlan;
				end
				fifo_reader_pkg::MT_WORD0: begin
					dst_tab[p] <= w0_dst;
					src_tab[p][47:32] <= w0_src_hi;
				end
				fifo_reader_pkg::MT_WORD1: begin
					src_tab[p][31:0] <= w1_src_lo;
					first4_tab[p] <= rd_data.bytes[7:4];
				end
				default: begin
				end
			endcase
		end
		// Route for the frame, picked up when it starts forwarding
		if (rsp_valid)
			route_tab[rsp.port] <= rsp;
	end

	////////////////////////////////////////////////////////////
	// Lookup request, held until accepted

	always_ff @(posedge clk) begin
		if (word1_ret) begin
			req.port <= p;
			req.vlan <= vlan_tab[p];
			// Low half of source MAC is still on the bus this cycle
			req.src_mac <= {src_tab[p][47:32], w1_src_lo};
			req.dst_mac <= dst_tab[p];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			req_valid <= 1'b0;
		else if (word1_ret)
			req_valid <= 1'b1;
		else if (req_ready)
			req_valid <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Fields of the selected port, first two beats rebuilt

	logic [`MAC_W-1:0] sel_dst_sw;
	logic [15:0] sel_src_hi_sw;
	logic [31:0] sel_src_lo_sw;

	always_comb begin
		sel_dst_sw = {<<8{dst_tab[sel_port]}};
		sel_src_hi_sw = {<<8{src_tab[sel_port][47:32]}};
		sel_src_lo_sw = {<<8{src_tab[sel_port][31:0]}};
	end

	assign sel_len = len_tab[sel_port];
	assign sel_vlan = vlan_tab[sel_port];
	assign sel_route = route_tab[sel_port];
	// Beat0 is dest MAC then top of source MAC, beat1 the rest of it then first4
	assign sel_beat0 = {sel_src_hi_sw, sel_dst_sw};
	assign sel_beat1 = {first4_tab[sel_port], sel_src_lo_sw};

endmodule

// File: verilog/frame_byte_counter.sv
`include "fifo_reader_defines.svh"

module frame_byte_counter (
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic [`LEN_W-1:0] len,
	input  logic read_issued,
	input  logic beat_pushed,
	output logic [`LEN_W-1:0] reads_left,
	output logic [`WORD_W/8-1:0] strb,
	output logic last
);

	localparam logic [`LEN_W-1:0] BEAT_BYTES = `LEN_W'(`WORD_W/8);
	// First two payload words were read while parsing
	localparam logic [`LEN_W-1:0] PARSED_BYTES = `LEN_W'(2*`WORD_W/8);

	logic [`LEN_W-1:0] send_left;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			send_left <= '0;
			reads_left <= '0;
		end else if (load) begin
			send_left <= len;
			reads_left <= len - PARSED_BYTES;
		end else begin
			// Both count down a beat at a time and stop at zero
			if (read_issued)
				reads_left <= (reads_left > BEAT_BYTES) ? reads_left - BEAT_BYTES : '0;
			if (beat_pushed)
				send_left <= (send_left > BEAT_BYTES) ? send_left - BEAT_BYTES : '0;
		end
	end

	// Final beat keeps only the remaining bytes
	assign last = (send_left <= BEAT_BYTES);
	assign strb = last ? ~(8'hff << send_left[3:0]) : 8'hff;

endmodule

// File: verilog/tx_out_buffer.sv
`include "fifo_reader_defines.svh"

module tx_out_buffer (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  fifo_reader_pkg::tx_beat_t push_beat,
	output fifo_reader_pkg::tx_beat_t tx_beat,
	output logic tx_valid,
	input  logic tx_ready,
	output logic [`OUT_CNT_W-1:0] free_slots,
	output logic empty
);

	localparam int IDX_W = $clog2(`OUT_DEPTH);

	fifo_reader_pkg::tx_beat_t beats [`OUT_DEPTH];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic [`OUT_CNT_W-1:0] count;
	logic pop;

	// Beat leaves on valid and ready together
	assign pop = tx_valid && tx_ready;

	always_ff @(posedge clk) begin
		if (push)
			beats[wr_idx] <= push_beat;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_idx <= '0;
			rd_idx <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_idx <= wr_idx + 1'b1;
			if (pop)
				rd_idx <= rd_idx + 1'b1;
			count <= count + `OUT_CNT_W'(push) - `OUT_CNT_W'(pop);
		end
	end

	assign tx_beat = beats[rd_idx];
	assign tx_valid = (count != '0);
	assign empty = (count == '0);
	// Read credit, checked against reads still in flight
	assign free_slots = `OUT_CNT_W'(`OUT_DEPTH) - count;

endmodule

// File: verilog/reader_fsm.sv
`include "fifo_reader_defines.svh"

module reader_fsm (
	input  logic clk,
	input  logic rst_n,
	input  fifo_reader_pkg::ptr_vec_t wr_ptr_committed,
	output fifo_reader_pkg::ptr_vec_t rd_ptr,
	output logic rd_en,
	output logic [`MEM_ADDR_W-1:0] rd_addr,
	output fifo_reader_pkg::read_tag_t rd_tag,
	input  logic rd_valid,
	input  fifo_reader_pkg::mem_word_u rd_data,
	input  fifo_reader_pkg::read_tag_t head_tag,
	input  logic [`TAG_CNT_W-1:0] tags_in_flight,
	input  logic rsp_valid,
	input  fifo_reader_pkg::lookup_rsp_t rsp,
	input  logic req_valid,
	output logic [`PORT_BITS-1:0] sel_port,
	input  logic [`VLAN_W-1:0] sel_vlan,
	input  logic [`WORD_W-1:0] sel_beat0,
	input  logic [`WORD_W-1:0] sel_beat1,
	input  fifo_reader_pkg::lookup_rsp_t sel_route,
	output logic cnt_load,
	output logic read_issued,
	input  logic [`LEN_W-1:0] reads_left,
	input  logic [`WORD_W/8-1:0] strb,
	input  logic last,
	output logic buf_push,
	output fifo_reader_pkg::tx_beat_t buf_beat,
	input  logic [`OUT_CNT_W-1:0] free_slots,
	input  logic buf_empty
);

	fifo_reader_pkg::port_state_e port_state [`NUM_PORTS];
	fifo_reader_pkg::port_state_e rr_state;
	fifo_reader_pkg::fwd_step_e fwd_step;
	logic [`PORT_BITS-1:0] rr_port;
	logic [`PORT_BITS-1:0] fwd_port;
	logic parse_busy;
	logic start_fwd;
	logic done_fwd;
	logic hold_rr;

	////////////////////////////////////////////////////////////
	// Read issue and beat push, decided from registered state

	always_comb begin
		rr_state = port_state[rr_port];
		// One frame parsed at a time, and one lookup outstanding
		parse_busy = req_valid;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			if (port_state[i] inside {fifo_reader_pkg::PS_HEADER, fifo_reader_pkg::PS_WORD0,
					fifo_reader_pkg::PS_WORD1})
				parse_busy = 1'b1;
		end
		rd_en = 1'b0;
		rd_tag.mtype = fifo_reader_pkg::MT_HEADER;
		rd_tag.port = rr_port;
		start_fwd = 1'b0;
		buf_push = 1'b0;
		buf_beat.data = rd_data;
		if (fwd_step == fifo_reader_pkg::FS_IDLE) begin
			case (rr_state)
				fifo_reader_pkg::PS_IDLE:
					rd_en = (wr_ptr_committed[rr_port] != rd_ptr[rr_port]) && !parse_busy;
				fifo_reader_pkg::PS_HEADER: begin
					rd_en = 1'b1;
					rd_tag.mtype = fifo_reader_pkg::MT_WORD0;
				end
				fifo_reader_pkg::PS_WORD0: begin
					rd_en = 1'b1;
					rd_tag.mtype = fifo_reader_pkg::MT_WORD1;
				end
				// Start with an empty buffer, the body credit depends on it
				fifo_reader_pkg::PS_FWD_READY:
					start_fwd = buf_empty;
				default: begin
				end
			endcase
		end else begin
			rd_tag.port = fwd_port;
			rd_tag.mtype = fifo_reader_pkg::MT_BODY;
			case (fwd_step)
				fifo_reader_pkg::FS_BEAT0: begin
					buf_push = 1'b1;
					buf_beat.data = sel_beat0;
				end
				fifo_reader_pkg::FS_BEAT1: begin
					buf_push = 1'b1;
					buf_beat.data = sel_beat1;
				end
				default: begin
					// Every read in flight has a slot waiting for it
					rd_en = (reads_left != '0) && (free_slots > tags_in_flight);
					buf_push = rd_valid && (head_tag.mtype == fifo_reader_pkg::MT_BODY);
				end
			endcase
		end
		rd_addr = {rd_tag.port, rd_ptr[rd_tag.port][`PTR_BITS-1:0]};
		read_issued = rd_en && (rd_tag.mtype == fifo_reader_pkg::MT_BODY);
		// Header and word0 reads keep the scheduler on this port
		hold_rr = rd_en && (rd_tag.mtype inside {fifo_reader_pkg::MT_HEADER,
			fifo_reader_pkg::MT_WORD0});
		cnt_load = start_fwd;
		sel_port = (fwd_step == fifo_reader_pkg::FS_IDLE) ? rr_port : fwd_port;
		// Counter and route fill in the rest of every beat
		buf_beat.strb = strb;
		buf_beat.last = last;
		buf_beat.dst_port = sel_route.dst_port;
		buf_beat.broadcast = sel_route.broadcast;
		buf_beat.vlan = sel_vlan;
		done_fwd = buf_push && last;
	end

	////////////////////////////////////////////////////////////
	// Port states, pointers, scheduler and forwarding step

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				port_state[i] <= fifo_reader_pkg::PS_IDLE;
				rd_ptr[i] <= '0;
			end
			rr_port <= '0;
			fwd_port <= '0;
			fwd_step <= fifo_reader_pkg::FS_IDLE;
		end else begin
			if (rd_en)
				rd_ptr[rd_tag.port] <= rd_ptr[rd_tag.port] + 1'b1;
			// Word1 back, lookup request goes out next cycle
			if (rd_valid && (head_tag.mtype == fifo_reader_pkg::MT_WORD1))
				port_state[head_tag.port] <= fifo_reader_pkg::PS_LOOKUP;
			if (rsp_valid)
				port_state[rsp.port] <= fifo_reader_pkg::PS_FWD_READY;
			if (fwd_step == fifo_reader_pkg::FS_IDLE) begin
				case (rr_state)
					fifo_reader_pkg::PS_IDLE: begin
						if (rd_en)
							port_state[rr_port] <= fifo_reader_pkg::PS_HEADER;
					end
					fifo_reader_pkg::PS_HEADER:
						port_state[rr_port] <= fifo_reader_pkg::PS_WORD0;
					fifo_reader_pkg::PS_WORD0:
						port_state[rr_port] <= fifo_reader_pkg::PS_WORD1;
					fifo_reader_pkg::PS_FWD_READY: begin
						if (start_fwd) begin
							port_state[rr_port] <= fifo_reader_pkg::PS_FORWARDING;
							fwd_port <= rr_port;
							fwd_step <= fifo_reader_pkg::FS_BEAT0;
						end
					end
					default: begin
					end
				endcase
				if (!hold_rr)
					rr_port <= (rr_port == `PORT_BITS'(`NUM_PORTS - 1)) ? '0 : rr_port + 1'b1;
			end else if (done_fwd) begin
				fwd_step <= fifo_reader_pkg::FS_IDLE;
				port_state[fwd_port] <= fifo_reader_pkg::PS_IDLE;
			end else if (fwd_step == fifo_reader_pkg::FS_BEAT0) begin
				fwd_step <= fifo_reader_pkg::FS_BEAT1;
			end else begin
				fwd_step <= fifo_reader_pkg::FS_BODY;
			end
		end
	end

endmodule

// File: verilog/line_card_fifo_reader.sv
`include "fifo_reader_defines.svh"

module line_card_fifo_reader (
	input  logic clk,
	input  logic rst_n,
	input  fifo_reader_pkg::ptr_vec_t wr_ptr_committed,
	output fifo_reader_pkg::ptr_vec_t rd_ptr,
	output logic rd_en,
	output logic [`MEM_ADDR_W-1:0] rd_addr,
	input  fifo_reader_pkg::mem_word_u rd_data,
	input  logic rd_valid,
	output fifo_reader_pkg::lookup_req_t lookup_req,
	output logic lookup_valid,
	input  logic lookup_ready,
	input  fifo_reader_pkg::lookup_rsp_t lookup_rsp,
	input  logic rsp_valid,
	output fifo_reader_pkg::tx_beat_t tx_beat,
	output logic tx_valid,
	input  logic tx_ready
);

	// Read tags
	fifo_reader_pkg::read_tag_t rd_tag;
	fifo_reader_pkg::read_tag_t head_tag;
	logic [`TAG_CNT_W-1:0] tags_in_flight;

	// Fields of the selected port
	logic [`PORT_BITS-1:0] sel_port;
	logic [`LEN_W-1:0] sel_len;
	logic [`VLAN_W-1:0] sel_vlan;
	logic [`WORD_W-1:0] sel_beat0;
	logic [`WORD_W-1:0] sel_beat1;
	fifo_reader_pkg::lookup_rsp_t sel_route;

	// Byte counting and output buffer
	logic cnt_load;
	logic read_issued;
	logic [`LEN_W-1:0] reads_left;
	logic [`WORD_W/8-1:0] strb;
	logic last;
	logic buf_push;
	fifo_reader_pkg::tx_beat_t buf_beat;
	logic [`OUT_CNT_W-1:0] free_slots;
	logic buf_empty;

	read_tag_fifo read_tag_fifo_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push(rd_en),
		.push_tag(rd_tag),
		.pop(rd_valid),
		.head_tag(head_tag),
		.count(tags_in_flight)
	);

	port_frame_table port_frame_table_inst (
		.clk(clk),
		.rst_n(rst_n),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.head_tag(head_tag),
		.rsp_valid(rsp_valid),
		.rsp(lookup_rsp),
		.sel_port(sel_port),
		.req(lookup_req),
		.req_valid(lookup_valid),
		.req_ready(lookup_ready),
		.sel_len(sel_len),
		.sel_vlan(sel_vlan),
		.sel_beat0(sel_beat0),
		.sel_beat1(sel_beat1),
		.sel_route(sel_route)
	);

	frame_byte_counter frame_byte_counter_inst (
		.clk(clk),
		.rst_n(rst_n),
		.load(cnt_load),
		.len(sel_len),
		.read_issued(read_issued),
		.beat_pushed(buf_push),
		.reads_left(reads_left),
		.strb(strb),
		.last(last)
	);

	tx_out_buffer tx_out_buffer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.push(buf_push),
		.push_beat(buf_beat),
		.tx_beat(tx_beat),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.free_slots(free_slots),
		.empty(buf_empty)
	);

	reader_fsm reader_fsm_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wr_ptr_committed(wr_ptr_committed),
		.rd_ptr(rd_ptr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_tag(rd_tag),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.head_tag(head_tag),
		.tags_in_flight(tags_in_flight),
		.rsp_valid(rsp_valid),
		.rsp(lookup_rsp),
		.req_valid(lookup_valid),
		.sel_port(sel_port),
		.sel_vlan(sel_vlan),
		.sel_beat0(sel_beat0),
		.sel_beat1(sel_beat1),
		.sel_route(sel_route),
		.cnt_load(cnt_load),
		.read_issued(read_issued),
		.reads_left(reads_left),
		.strb(strb),
		.last(last),
		.buf_push(buf_push),
		.buf_beat(buf_beat),
		.free_slots(free_slots),
		.buf_empty(buf_empty)
	);

endmodule

// File: verif/tb_line_card_fifo_reader.sv
`include "fifo_reader_defines.svh"

module tb_line_card_fifo_reader;

	localparam int MAX_FRAMES = 64;
	localparam int FIELDS = 7;
	localparam int PORT_WORDS = 1 << `PTR_BITS;
	localparam int MEM_WORDS = `NUM_PORTS * PORT_WORDS;
	localparam int TIMEOUT = 20000;

	logic clk;
	logic rst_n;
	fifo_reader_pkg::ptr_vec_t wr_ptr_committed;
	fifo_reader_pkg::ptr_vec_t rd_ptr;
	logic rd_en;
	logic [`MEM_ADDR_W-1:0] rd_addr;
	fifo_reader_pkg::mem_word_u rd_data;
	logic rd_valid;
	fifo_reader_pkg::lookup_req_t lookup_req;
	logic lookup_valid;
	logic lookup_ready;
	fifo_reader_pkg::lookup_rsp_t lookup_rsp;
	logic rsp_valid;
	fifo_reader_pkg::tx_beat_t tx_beat;
	logic tx_valid;
	logic tx_ready;

	////////////////////////////////////////////////////////////
	// Stimulus, memory image and expected results

	logic [31:0] lcg_state;
	logic [47:0] stim [0:MAX_FRAMES*FIELDS-1];
	logic [`WORD_W-1:0] mem [0:MEM_WORDS-1];
	fifo_reader_pkg::ptr_vec_t wr_target;
	// Expected beats and lookups kept per port in frame order
	fifo_reader_pkg::tx_beat_t exp_beat [`NUM_PORTS][0:PORT_WORDS-1];
	fifo_reader_pkg::lookup_req_t exp_req [`NUM_PORTS][0:MAX_FRAMES-1];
	fifo_reader_pkg::lookup_rsp_t exp_rsp [`NUM_PORTS][0:MAX_FRAMES-1];
	int beat_wr [`NUM_PORTS];
	int beat_rd [`NUM_PORTS];
	int req_wr [`NUM_PORTS];
	int req_rd [`NUM_PORTS];
	int total_beats;
	int total_reqs;
	int beats_seen;
	int req_seen;
	int checks;
	int req_errors;
	int beat_errors;
	int final_errors;
	bit in_frame;
	int cur_port;
	int cycle;
	int lk_delay;
	// Reads pending in the memory model in issue order
	logic [`MEM_ADDR_W-1:0] pend_addr [$];
	int pend_due [$];

	line_card_fifo_reader line_card_fifo_reader_inst (
		.clk(clk),
		.rst_n(rst_n),
		.wr_ptr_committed(wr_ptr_committed),
		.rd_ptr(rd_ptr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.lookup_req(lookup_req),
		.lookup_valid(lookup_valid),
		.lookup_ready(lookup_ready),
		.lookup_rsp(lookup_rsp),
		.rsp_valid(rsp_valid),
		.tx_beat(tx_beat),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_lookup_req(input fifo_reader_pkg::lookup_req_t got,
			input fifo_reader_pkg::lookup_req_t exp);
		checks++;
		if (got !== exp) begin
			req_errors++;
			$display("[ERROR] %0t lookup request port %0d got %h expected %h",
				$time, exp.port, got, exp);
		end
	endtask

	task automatic verify_tx_beat(input fifo_reader_pkg::tx_beat_t got,
			input fifo_reader_pkg::tx_beat_t exp);
		checks++;
		if (got !== exp) begin
			beat_errors++;
			$display("[ERROR] %0t tx beat port %0d got %h expected %h",
				$time, cur_port, got, exp);
		end
	endtask

	task automatic match_read_ptrs(input fifo_reader_pkg::ptr_vec_t got,
			input fifo_reader_pkg::ptr_vec_t exp);
		checks++;
		if (got !== exp) begin
			final_errors++;
			$display("[ERROR] %0t read pointers got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic expect_flag(input logic got, input logic exp, input string name);
		checks++;
		if (got !== exp) begin
			final_errors++;
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Frame builder

	task automatic build_frames();
		int p;
		int len;
		int nw;
		int wp [`NUM_PORTS];
		logic [7:0] fbytes [0:255];
		logic [47:0] dst;
		logic [47:0] src;
		logic [31:0] rnd;
		fifo_reader_pkg::mem_word_u w;
		fifo_reader_pkg::tx_beat_t b;
		// Unused words carry their own address
		for (int a = 0; a < MEM_WORDS; a++)
			mem[a] = {32'hdead0000 | 32'(a), 32'(a) * 32'h9e3779b1};
		for (int i = 0; i < `NUM_PORTS; i++)
			wp[i] = 0;
		for (int f = 0; f < MAX_FRAMES; f++) begin
			if (stim[f*FIELDS] == 48'hffffffffffff)
				break;
			p = int'(stim[f*FIELDS][1:0]);
			len = int'(stim[f*FIELDS+1][`LEN_W-1:0]);
			dst = stim[f*FIELDS+3];
			src = stim[f*FIELDS+4];
			nw = (len + 7) / 8;
			w = '0;
			w.hdr.len = `LEN_W'(len);
			w.hdr.vlan = stim[f*FIELDS+2][`VLAN_W-1:0];
			mem[p*PORT_WORDS + wp[p]] = w;
			wp[p]++;
			// Wire order puts MACs most significant byte first
			for (int i = 0; i < nw*8; i++) begin
				if (i < 6) begin
					fbytes[i] = dst[47-8*i -: 8];
				end else if (i < 12) begin
					fbytes[i] = src[47-8*(i-6) -: 8];
				end else begin
					rnd = lcg_next();
					fbytes[i] = rnd[23:16];
				end
			end
			for (int j = 0; j < nw; j++) begin
				for (int k = 0; k < 8; k++)
					w.bytes[k] = fbytes[8*j+k];
				mem[p*PORT_WORDS + wp[p]] = w;
				wp[p]++;
				b.data = w;
				b.last = (j == nw - 1);
				if (b.last && (len % 8 != 0))
					b.strb = 8'((1 << (len % 8)) - 1);
				else
					b.strb = 8'hff;
				b.dst_port = stim[f*FIELDS+5][1:0];
				b.broadcast = stim[f*FIELDS+6][0];
				b.vlan = stim[f*FIELDS+2][`VLAN_W-1:0];
				exp_beat[p][beat_wr[p]] = b;
				beat_wr[p]++;
				total_beats++;
			end
			exp_req[p][req_wr[p]] = {2'(p), stim[f*FIELDS+2][`VLAN_W-1:0], src, dst};
			exp_rsp[p][req_wr[p]] = {2'(p), stim[f*FIELDS+5][1:0], stim[f*FIELDS+6][0]};
			req_wr[p]++;
			total_reqs++;
		end
		for (int i = 0; i < `NUM_PORTS; i++)
			wr_target[i] = `FIFO_PTR_W'(wp[i]);
	endtask

	////////////////////////////////////////////////////////////
	// Models and monitor

	always @(posedge clk)
		cycle <= cycle + 1;

	// In-order memory with 1 to 4 cycles of latency
	always @(posedge clk) begin
		if (!rst_n) begin
			rd_valid <= 1'b0;
		end else begin
			if (rd_en) begin
				pend_addr.push_back(rd_addr);
				pend_due.push_back(cycle + int'(lcg_next() % 4));
			end
			if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
				rd_valid <= 1'b1;
				rd_data <= mem[pend_addr.pop_front()];
				void'(pend_due.pop_front());
			end else begin
				rd_valid <= 1'b0;
			end
		end
	end

	// Lookup responder accepts after a random delay and answers next cycle
	always @(posedge clk) begin
		if (!rst_n) begin
			lookup_ready <= 1'b0;
			rsp_valid <= 1'b0;
			lk_delay <= 0;
		end else if (lookup_valid && lookup_ready) begin
			lookup_ready <= 1'b0;
			lk_delay <= int'(lcg_next() % 4);
			if (req_rd[lookup_req.port] < req_wr[lookup_req.port]) begin
				check_lookup_req(lookup_req, exp_req[lookup_req.port][req_rd[lookup_req.port]]);
				rsp_valid <= 1'b1;
				lookup_rsp <= exp_rsp[lookup_req.port][req_rd[lookup_req.port]];
				req_rd[lookup_req.port]++;
				req_seen++;
			end else begin
				req_errors++;
				rsp_valid <= 1'b0;
				$display("Unexpected lookup request for port %0d at %0t", lookup_req.port, $time);
			end
		end else begin
			rsp_valid <= 1'b0;
			if (lookup_valid) begin
				if (lk_delay == 0)
					lookup_ready <= 1'b1;
				else
					lk_delay <= lk_delay - 1;
			end
		end
	end

	always @(posedge clk) begin
		if (!rst_n)
			tx_ready <= 1'b0;
		else
			tx_ready <= (lcg_next() % 4) != 0;
	end

	// The first beat's data and VLAN pick the port whose next frame it opens
	task automatic take_tx_beat(input fifo_reader_pkg::tx_beat_t got);
		int found;
		found = -1;
		if (!in_frame) begin
			for (int p = `NUM_PORTS - 1; p >= 0; p--) begin
				if (beat_rd[p] < beat_wr[p] && exp_beat[p][beat_rd[p]].data == got.data
						&& exp_beat[p][beat_rd[p]].vlan == got.vlan)
					found = p;
			end
			cur_port = found;
		end
		beats_seen++;
		if (cur_port < 0 || beat_rd[cur_port] >= beat_wr[cur_port]) begin
			beat_errors++;
			$display("Beat %h at %0t belongs to no expected frame", got.data, $time);
		end else begin
			verify_tx_beat(got, exp_beat[cur_port][beat_rd[cur_port]]);
			beat_rd[cur_port]++;
			in_frame = !got.last;
		end
	endtask

	always @(posedge clk) begin
		if (rst_n && tx_valid && tx_ready)
			take_tx_beat(tx_beat);
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		int wait_cyc;
		bit timed_out;
		rst_n = 1'b0;
		wr_ptr_committed = '0;
		rd_valid = 1'b0;
		rd_data = '0;
		lookup_ready = 1'b0;
		lookup_rsp = '0;
		rsp_valid = 1'b0;
		tx_ready = 1'b0;
		lcg_state = 32'h9f055ba5;
		cycle = 0;
		timed_out = 1'b0;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			beat_wr[i] = 0;
			beat_rd[i] = 0;
			req_wr[i] = 0;
			req_rd[i] = 0;
		end
		for (int i = 0; i < MAX_FRAMES*FIELDS; i++)
			stim[i] = '1;
		$readmemh("verif/reader_stimulus.txt", stim);
		build_frames();
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		wr_ptr_committed <= wr_target;
		wait_cyc = 0;
		while (beats_seen < total_beats && wait_cyc < TIMEOUT) begin
			@(posedge clk);
			wait_cyc++;
		end
		if (beats_seen < total_beats) begin
			timed_out = 1'b1;
			$display("Timeout: %0d of %0d beats arrived", beats_seen, total_beats);
		end
		wait_cyc = 0;
		while ((tx_valid || lookup_valid) && wait_cyc < 100) begin
			@(posedge clk);
			wait_cyc++;
		end
		if (tx_valid || lookup_valid) begin
			timed_out = 1'b1;
			$display("Timeout: outputs still valid after the last frame");
		end
		// A few idle cycles to catch stray beats or requests
		repeat (10) @(posedge clk);
		if (req_seen != total_reqs) begin
			req_errors++;
			$display("Only %0d of %0d lookup requests arrived", req_seen, total_reqs);
		end
		$display("Test lookup requests: %0d of %0d seen, %0d errors",
			req_seen, total_reqs, req_errors);
		$display("Test tx beats: %0d of %0d seen, %0d errors",
			beats_seen, total_beats, beat_errors);
		match_read_ptrs(rd_ptr, wr_target);
		expect_flag(tx_valid, 1'b0, "tx_valid");
		expect_flag(lookup_valid, 1'b0, "lookup_valid");
		$display("Test final state: %0d errors", final_errors);
		$display("Checks %0d, errors %0d", checks, req_errors + beat_errors + final_errors);
		if (!timed_out && beats_seen == total_beats
				&& req_errors + beat_errors + final_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+verilog
verilog/fifo_reader_pkg.sv
verilog/read_tag_fifo.sv
verilog/port_frame_table.sv
verilog/frame_byte_counter.sv
verilog/tx_out_buffer.sv
verilog/reader_fsm.sv
verilog/line_card_fifo_reader.sv
verif/tb_line_card_fifo_reader.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the line card FIFO reader testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_line_card_fifo_reader \
	-o sim_tb_line_card_fifo_reader

./obj_dir/sim_tb_line_card_fifo_reader > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "TESTS PASSED" sim.log

// File: verif/reader_stimulus.txt
// Columns: port, length in bytes, VLAN, destination MAC, source MAC,
// expected destination port, broadcast flag (all hex)
0 010 001 0a0000000001 0b0000000101 1 0
1 011 002 0a0000000002 0b0000000102 2 0
2 018 003 0a0000000003 0b0000000103 3 0
3 01f 004 0a0000000004 0b0000000104 0 0
0 020 005 ffffffffffff 0b0000000105 0 1
1 027 006 0a0000000006 0b0000000106 3 0
2 028 007 0a0000000007 0b0000000107 1 0
3 03c 008 0a0000000008 0b0000000108 2 0
0 040 009 0a0000000009 0b0000000109 3 0
1 041 00a ffffffffffff 0b000000010a 1 1
2 045 00b 0a000000000b 0b000000010b 0 0
3 050 00c 0a000000000c 0b000000010c 1 0
0 05d 00d 0a000000000d 0b000000010d 2 0
1 060 00e 0a000000000e 0b000000010e 0 0
2 066 00f 0a000000000f 0b000000010f 3 0
3 070 010 ffffffffffff 0b0000000110 3 1
0 077 011 0a0000000011 0b0000000111 1 0
1 078 012 0a0000000012 0b0000000112 2 0
2 013 013 0a0000000013 0b0000000113 0 0
3 021 014 0a0000000014 0b0000000114 2 0
0 02e 015 0a0000000015 0b0000000115 0 0
1 035 016 0a0000000016 0b0000000116 3 0
2 048 017 ffffffffffff 0b0000000117 2 1
3 059 018 0a0000000018 0b0000000118 1 0
0 064 019 0a0000000019 0b0000000119 2 0
1 06b 01a 0a000000001a 0b000000011a 0 0
// End marker
ffffffffffff 0 0 0 0 0 0
